//--- build.f
+incdir+logic
logic/bg_pkg.sv
logic/scanline_ram.sv
logic/bg_regs.sv
logic/tile_fetcher.sv
logic/scanline_mixer.sv
logic/bg_renderer.sv
tb/bg_checker.sv
tb/bg_renderer_tb.sv

//--- logic/bg_params.svh
`ifndef BG_PARAMS_SVH
`define BG_PARAMS_SVH

// Tile side in pixels
`define BG_TILE_SIZE      16

// Buffer columns where a line is rendered
`define BG_RENDER_X_START 10'd32
`define BG_RENDER_X_END   10'd720

// 4 pixels per scanline RAM word
`define BG_LINE_WORDS     256

// Register map, layer 0 then layer 1
`define BG_REG_CTRL0      4'd0
`define BG_REG_MAPX0      4'd1
`define BG_REG_MAPY0      4'd2
`define BG_REG_MAP0       4'd3
`define BG_REG_SET0       4'd4
`define BG_REG_CTRL1      4'd5
`define BG_REG_MAPX1      4'd6
`define BG_REG_MAPY1      4'd7
`define BG_REG_MAP1       4'd8
`define BG_REG_SET1       4'd9

`endif

//--- logic/bg_pkg.sv
`default_nettype none

package bg_pkg;

	// Settings of one background layer
	typedef struct packed {
		logic        enable;
		logic [3:0]  pal_hi;
		logic [15:0] map_x;
		logic [15:0] map_y;
		logic [15:0] map_addr;
		logic [15:0] set_addr;
	} bg_layer_cfg_t;

	// Control register layout
	typedef struct packed {
		logic [7:0] rsvd_hi;
		logic [3:0] pal_hi;
		logic [2:0] rsvd_lo;
		logic       enable;
	} bg_reg_ctrl_t;

	// Write word, decoded by register address
	typedef union packed {
		bg_reg_ctrl_t ctrl;
		logic [15:0]  value;
	} bg_reg_word_u;

	typedef struct packed {
		logic         valid;
		logic [3:0]   addr;
		bg_reg_word_u data;
	} bg_reg_write_t;

	// Word read request towards memory
	typedef struct packed {
		logic        valid;
		logic [15:0] addr;
	} bg_mem_req_t;

	// One word into a back buffer
	typedef struct packed {
		logic        en;
		logic        layer;
		logic [7:0]  addr;
		logic [15:0] data;
	} bg_line_write_t;

endpackage

`default_nettype wire

//--- logic/bg_regs.sv
`timescale 1ns/1ps
`default_nettype none
`include "bg_params.svh"

module bg_regs (
	input  wire                     CLK,
	input  wire                     RSTb,
	input  wire bg_pkg::bg_reg_write_t reg_wr,
	output bg_pkg::bg_layer_cfg_t   cfg0,
	output bg_pkg::bg_layer_cfg_t   cfg1
);

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			cfg0 <= '0;
			cfg1 <= '0;
		end else if (reg_wr.valid) begin
			case (reg_wr.addr)
				`BG_REG_CTRL0: begin
					cfg0.enable <= reg_wr.data.ctrl.enable;
					cfg0.pal_hi <= reg_wr.data.ctrl.pal_hi;
				end
				`BG_REG_MAPX0: begin
					cfg0.map_x <= reg_wr.data.value;
				end
				`BG_REG_MAPY0: begin
					cfg0.map_y <= reg_wr.data.value;
				end
				`BG_REG_MAP0: begin
					cfg0.map_addr <= reg_wr.data.value;
				end
				`BG_REG_SET0: begin
					cfg0.set_addr <= reg_wr.data.value;
				end
				`BG_REG_CTRL1: begin
					cfg1.enable <= reg_wr.data.ctrl.enable;
					cfg1.pal_hi <= reg_wr.data.ctrl.pal_hi;
				end
				`BG_REG_MAPX1: begin
					cfg1.map_x <= reg_wr.data.value;
				end
				`BG_REG_MAPY1: begin
					cfg1.map_y <= reg_wr.data.value;
				end
				`BG_REG_MAP1: begin
					cfg1.map_addr <= reg_wr.data.value;
				end
				`BG_REG_SET1: begin
					cfg1.set_addr <= reg_wr.data.value;
				end
				// Addresses 10 to 15 are ignored
				default: begin
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- logic/bg_renderer.sv
`timescale 1ns/1ps
`default_nettype none

module bg_renderer (
	input  wire                        CLK,
	input  wire                        RSTb,
	input  wire bg_pkg::bg_reg_write_t  reg_wr,
	input  wire                        h_tick,
	input  wire  [9:0]                 display_x,
	input  wire  [9:0]                 display_y,
	output logic [7:0]                 color_index,
	output bg_pkg::bg_mem_req_t         mem_req,
	input  wire                        mem_ready,
	input  wire  [15:0]                mem_data
);

	import bg_pkg::*;

	bg_layer_cfg_t  cfg0;
	bg_layer_cfg_t  cfg1;
	bg_line_write_t line_wr;
	logic           active_buffer;

	bg_regs u_regs (
		.CLK    (CLK),
		.RSTb   (RSTb),
		.reg_wr (reg_wr),
		.cfg0   (cfg0),
		.cfg1   (cfg1)
	);

	tile_fetcher u_fetcher (
		.CLK           (CLK),
		.RSTb          (RSTb),
		.cfg0          (cfg0),
		.cfg1          (cfg1),
		.h_tick        (h_tick),
		.display_y     (display_y),
		.mem_req       (mem_req),
		.mem_ready     (mem_ready),
		.mem_data      (mem_data),
		.line_wr       (line_wr),
		.active_buffer (active_buffer)
	);

	scanline_mixer u_mixer (
		.CLK           (CLK),
		.RSTb          (RSTb),
		.cfg0          (cfg0),
		.cfg1          (cfg1),
		.line_wr       (line_wr),
		.active_buffer (active_buffer),
		.display_x     (display_x),
		.color_index   (color_index)
	);

endmodule

`default_nettype wire

//--- logic/scanline_mixer.sv
`timescale 1ns/1ps
`default_nettype none
`include "bg_params.svh"

module scanline_mixer (
	input  wire                        CLK,
	input  wire                        RSTb,
	input  wire bg_pkg::bg_layer_cfg_t  cfg0,
	input  wire bg_pkg::bg_layer_cfg_t  cfg1,
	input  wire bg_pkg::bg_line_write_t line_wr,
	input  wire                        active_buffer,
	input  wire  [9:0]                 display_x,
	output logic [7:0]                 color_index
);

	localparam int ABITS = $clog2(`BG_LINE_WORDS);

	logic [9:0]       col [2];
	logic [ABITS-1:0] clr_addr;
	logic [ABITS-1:0] ram_rd_addr [4];
	logic [15:0]      ram_rd_data [4];
	logic [ABITS-1:0] ram_wr_addr [4];
	logic [15:0]      ram_wr_data [4];
	logic             ram_wr [4];

	logic [1:0]       col_lo_d [2];
	logic             front_d;
	logic [15:0]      front0;
	logic [15:0]      front1;
	logic [3:0]       nib0;
	logic [3:0]       nib1;

	// Scrolled buffer column per layer
	assign col[0] = display_x + {6'd0, cfg0.map_x[3:0]};
	assign col[1] = display_x + {6'd0, cfg1.map_x[3:0]};

	// Word just behind the beam
	assign clr_addr = display_x[ABITS+1:2] - 1'b1;

	// RAM index is {layer, buffer}
	for (genvar j = 0; j < 4; j++) begin : g_buf
		localparam int LAYER = j / 2;
		localparam bit BUF = (j % 2) == 1;

		logic front;

		assign front          = (BUF != active_buffer);
		assign ram_wr[j]      = front | (line_wr.en && (line_wr.layer == (LAYER == 1)));
		assign ram_wr_addr[j] = front ? clr_addr : line_wr.addr;
		assign ram_wr_data[j] = front ? 16'h0000 : line_wr.data;
		assign ram_rd_addr[j] = col[LAYER][ABITS+1:2];

		scanline_ram #(
			.DATA_BITS(16),
			.ADDR_BITS(ABITS)
		) u_ram (
			.CLK     (CLK),
			.rd_addr (ram_rd_addr[j]),
			.rd_data (ram_rd_data[j]),
			.wr_addr (ram_wr_addr[j]),
			.wr_data (ram_wr_data[j]),
			.wr      (ram_wr[j])
		);
	end

	// Follow the RAM read latency
	always_ff @(posedge CLK) begin
		col_lo_d[0] <= col[0][1:0];
		col_lo_d[1] <= col[1][1:0];
		front_d     <= ~active_buffer;
	end

	assign front0 = ram_rd_data[{1'b0, front_d}];
	assign front1 = ram_rd_data[{1'b1, front_d}];
	assign nib0   = front0[{col_lo_d[0], 2'b00} +: 4];
	assign nib1   = front1[{col_lo_d[1], 2'b00} +: 4];

	// Layer 0 wins unless its nibble is zero
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			color_index <= 8'd0;
		end else if (nib0 != 4'd0) begin
			color_index <= {cfg0.pal_hi, nib0};
		end else if (cfg1.enable) begin
			color_index <= {cfg1.pal_hi, nib1};
		end else begin
			color_index <= 8'd0;
		end
	end

endmodule

`default_nettype wire

//--- logic/scanline_ram.sv
`timescale 1ns/1ps
`default_nettype none

module scanline_ram #(
	parameter int DATA_BITS = 16,
	parameter int ADDR_BITS = 8
) (
	input  wire                  CLK,
	input  wire  [ADDR_BITS-1:0] rd_addr,
	output logic [DATA_BITS-1:0] rd_data,
	input  wire  [ADDR_BITS-1:0] wr_addr,
	input  wire  [DATA_BITS-1:0] wr_data,
	input  wire                  wr
);

	logic [DATA_BITS-1:0] mem [2**ADDR_BITS];

	// Registered read, old data on a same-address write
	always_ff @(posedge CLK) begin
		if (wr) begin
			mem[wr_addr] <= wr_data;
		end
		rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

//--- logic/tile_fetcher.sv
`timescale 1ns/1ps
`default_nettype none
`include "bg_params.svh"

module tile_fetcher (
	input  wire                       CLK,
	input  wire                       RSTb,
	input  wire bg_pkg::bg_layer_cfg_t cfg0,
	input  wire bg_pkg::bg_layer_cfg_t cfg1,
	input  wire                       h_tick,
	input  wire  [9:0]                display_y,
	output bg_pkg::bg_mem_req_t       mem_req,
	input  wire                       mem_ready,
	input  wire  [15:0]               mem_data,
	output bg_pkg::bg_line_write_t    line_wr,
	output logic                      active_buffer
);

	import bg_pkg::*;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_BEGIN,
		ST_FETCH_MAP,
		ST_WAIT_MAP,
		ST_FETCH_DATA,
		ST_WAIT_DATA
	} state_t;

	state_t        state;
	logic          layer;
	logic [9:0]    render_x;
	logic [16:0]   map_index;
	logic [7:0]    cur_tile;
	logic [1:0]    quarter;

	bg_layer_cfg_t cur_cfg;
	logic [15:0]   row_y;
	logic [16:0]   map_start;
	logic [15:0]   tile_addr;

	assign cur_cfg = layer ? cfg1 : cfg0;

	// Map line for this scanline
	assign row_y = cur_cfg.map_y + {6'd0, display_y};

	// Byte index of the first visible tile on the map row
	assign map_start = {cur_cfg.map_addr, 1'b0}
		+ {3'd0, row_y[10:4], 7'd0}
		+ {10'd0, cur_cfg.map_x[10:4]};

	// First word of the tile row; tile sets are 16 tiles wide
	assign tile_addr = cur_cfg.set_addr
		+ {2'd0, cur_tile[7:4], 10'd0}
		+ {10'd0, cur_tile[3:0], 2'd0}
		+ {6'd0, row_y[3:0], 6'd0};

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state         <= ST_IDLE;
			layer         <= 1'b0;
			active_buffer <= 1'b0;
			mem_req.valid <= 1'b0;
			line_wr.en    <= 1'b0;
		end else begin
			line_wr.en <= 1'b0;
			if (h_tick && cfg0.enable) begin
				// New line, restart even if the last one is unfinished
				state         <= ST_BEGIN;
				layer         <= 1'b0;
				active_buffer <= ~active_buffer;
				mem_req.valid <= 1'b0;
			end else begin
				case (state)
					ST_BEGIN: begin
						map_index <= map_start;
						render_x  <= `BG_RENDER_X_START;
						state     <= ST_FETCH_MAP;
					end
					ST_FETCH_MAP: begin
						if (render_x == `BG_RENDER_X_END) begin
							if (!layer && cfg1.enable) begin
								layer <= 1'b1;
								state <= ST_BEGIN;
							end else begin
								state <= ST_IDLE;
							end
						end else begin
							mem_req.valid <= 1'b1;
							mem_req.addr  <= map_index[16:1];
							state         <= ST_WAIT_MAP;
						end
					end
					ST_WAIT_MAP: begin
						if (mem_ready) begin
							// Even byte index is the low byte
							cur_tile      <= map_index[0] ? mem_data[15:8] : mem_data[7:0];
							mem_req.valid <= 1'b0;
							state         <= ST_FETCH_DATA;
						end
					end
					ST_FETCH_DATA: begin
						if (cur_tile == 8'hff) begin
							// Transparent, back buffer keeps its zeros
							render_x  <= render_x + 10'(`BG_TILE_SIZE);
							map_index <= map_index + 17'd1;
							state     <= ST_FETCH_MAP;
						end else begin
							mem_req.valid <= 1'b1;
							mem_req.addr  <= tile_addr;
							quarter       <= 2'd0;
							state         <= ST_WAIT_DATA;
						end
					end
					ST_WAIT_DATA: begin
						if (mem_ready) begin
							line_wr.en    <= 1'b1;
							line_wr.layer <= layer;
							line_wr.addr  <= render_x[9:2];
							line_wr.data  <= mem_data;
							render_x      <= render_x + 10'd4;
							quarter       <= quarter + 2'd1;
							if (quarter == 2'd3) begin
								mem_req.valid <= 1'b0;
								map_index     <= map_index + 17'd1;
								state         <= ST_FETCH_MAP;
							end else begin
								mem_req.addr <= mem_req.addr + 16'd1;
							end
						end
					end
					default: begin
						state <= ST_IDLE;
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- tb/bg_checker.sv
`timescale 1ns/1ps
`default_nettype none

module bg_checker (
	input  wire                      CLK,
	input  wire  [7:0]               color_index,
	input  wire bg_pkg::bg_mem_req_t mem_req,
	input  wire                      mem_ready,
	input  wire                      sweep_valid,
	input  wire  [9:0]               sweep_x,
	input  wire  [7:0]               sweep_exp,
	input  wire                      count_clear,
	input  wire                      count_check,
	input  wire  [31:0]              count_exp,
	input  wire                      test_end,
	input  wire                      run_done,
	output int                       error_count
);

	import bg_pkg::*;

	logic       v1;
	logic       v2;
	logic [9:0] x1;
	logic [9:0] x2;
	logic [7:0] e1;
	logic [7:0] e2;

	int handshakes   = 0;
	int test_num     = 1;
	int test_errors  = 0;
	int test_checks  = 0;
	int total_checks = 0;

	initial error_count = 0;

	// Expected value follows the two cycle display latency
	always @(posedge CLK) begin
		v1 <= sweep_valid;
		x1 <= sweep_x;
		e1 <= sweep_exp;
		v2 <= v1;
		x2 <= x1;
		e2 <= e1;

		if (count_clear) begin
			handshakes = 0;
		end else if (mem_req.valid && mem_ready) begin
			handshakes++;
		end

		if (v2) begin
			total_checks++;
			test_checks++;
			if (color_index !== e2) begin
				$display("ERR %0t color_index x=%0d expected %02h actual %02h",
					$time, x2, e2, color_index);
				error_count++;
				test_errors++;
			end
		end

		if (count_check) begin
			total_checks++;
			test_checks++;
			if (handshakes != count_exp) begin
				$display("ERR %0t mem handshakes expected %0d actual %0d",
					$time, count_exp, handshakes);
				error_count++;
				test_errors++;
			end
		end

		if (test_end) begin
			$display("test %0d: %s, %0d checks, %0d errors", test_num,
				(test_errors == 0) ? "ok" : "mismatch", test_checks, test_errors);
			test_num++;
			test_errors = 0;
			test_checks = 0;
		end

		if (run_done) begin
			$display("tests %0d, checks %0d, errors %0d",
				test_num - 1, total_checks, error_count);
		end
	end

endmodule

`default_nettype wire

//--- tb/bg_renderer_tb.sv
`timescale 1ns/1ps
`default_nettype none

module bg_renderer_tb;

	import bg_pkg::*;

	localparam int LINE_TIMEOUT = 50000;

	logic          CLK;
	logic          RSTb;
	bg_reg_write_t reg_wr;
	logic          h_tick;
	logic [9:0]    display_x;
	logic [9:0]    display_y;
	logic [7:0]    color_index;
	bg_mem_req_t   mem_req;
	logic          mem_ready;
	logic [15:0]   mem_data;

	logic          sweep_valid;
	logic [9:0]    sweep_x;
	logic [7:0]    sweep_exp;
	logic          count_clear;
	logic          count_check;
	int            count_exp;
	logic          test_end;
	logic          run_done;
	int            error_count;

	logic [15:0]   mem [65536];
	integer        seed;
	logic [31:0]   rnd;
	logic [1:0]    delay;
	logic          bp_on;
	logic          aborted;

	bg_renderer bg_renderer_inst (
		.CLK         (CLK),
		.RSTb        (RSTb),
		.reg_wr      (reg_wr),
		.h_tick      (h_tick),
		.display_x   (display_x),
		.display_y   (display_y),
		.color_index (color_index),
		.mem_req     (mem_req),
		.mem_ready   (mem_ready),
		.mem_data    (mem_data)
	);

	bg_checker u_checker (
		.CLK         (CLK),
		.color_index (color_index),
		.mem_req     (mem_req),
		.mem_ready   (mem_ready),
		.sweep_valid (sweep_valid),
		.sweep_x     (sweep_x),
		.sweep_exp   (sweep_exp),
		.count_clear (count_clear),
		.count_check (count_check),
		.count_exp   (count_exp),
		.test_end    (test_end),
		.run_done    (run_done),
		.error_count (error_count)
	);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	// Memory model with one word per handshake and an optional random delay
	always @(posedge CLK) begin
		if (!RSTb) begin
			mem_ready <= 1'b0;
			delay     <= 2'd0;
		end else if (mem_ready) begin
			mem_ready <= 1'b0;
		end else if (mem_req.valid) begin
			if (delay == 2'd0) begin
				mem_ready <= 1'b1;
				mem_data  <= mem[mem_req.addr];
				rnd = $random(seed);
				delay <= bp_on ? rnd[1:0] : 2'd0;
			end else begin
				delay <= delay - 2'd1;
			end
		end
	end

	task automatic write_reg(input logic [3:0] addr, input logic [15:0] value);
		@(posedge CLK);
		reg_wr <= {1'b1, addr, value};
		@(posedge CLK);
		reg_wr.valid <= 1'b0;
	endtask

	// Sweep the whole line so the front buffer ends up zero
	task automatic clear_front();
		int i;
		for (i = 0; i < 1024; i++) begin
			@(posedge CLK);
			display_x <= 10'(i);
		end
	endtask

	task automatic render_line(input logic [9:0] y);
		int low;
		int cycles;
		clear_front();
		@(posedge CLK);
		display_y   <= y;
		h_tick      <= 1'b1;
		count_clear <= 1'b1;
		@(posedge CLK);
		h_tick      <= 1'b0;
		count_clear <= 1'b0;
		low    = 0;
		cycles = 0;
		while (low < 16 && !aborted) begin
			@(posedge CLK);
			cycles++;
			if (mem_req.valid) begin
				low = 0;
			end else begin
				low++;
			end
			if (cycles > LINE_TIMEOUT) begin
				$display("Timeout: memory channel still busy after %0d cycles", cycles);
				aborted = 1'b1;
			end
		end
	endtask

	task automatic swap_line();
		@(posedge CLK);
		h_tick <= 1'b1;
		@(posedge CLK);
		h_tick <= 1'b0;
	endtask

	task automatic check_handshakes(input int n);
		@(posedge CLK);
		count_check <= 1'b1;
		count_exp   <= n;
		@(posedge CLK);
		count_check <= 1'b0;
	endtask

	task automatic expect_pixel(input logic [9:0] x, input logic [7:0] value);
		@(posedge CLK);
		display_x   <= x;
		sweep_valid <= 1'b1;
		sweep_x     <= x;
		sweep_exp   <= value;
	endtask

	// Let the last pixel leave the pipeline before closing
	task automatic close_test();
		@(posedge CLK);
		sweep_valid <= 1'b0;
		repeat (3) @(posedge CLK);
		test_end <= 1'b1;
		@(posedge CLK);
		test_end <= 1'b0;
	endtask

	task automatic report_bad_line(input string kind);
		$display("Malformed %s line in the test file", kind);
		aborted = 1'b1;
	endtask

	initial begin
		int    fd;
		int    a;
		int    b;
		int    code;
		int    i;
		string cmd;
		string rest;
		seed        = 32'h6bb90d1f;
		RSTb        = 1'b0;
		reg_wr      = '0;
		h_tick      = 1'b0;
		display_x   = '0;
		display_y   = '0;
		mem_ready   = 1'b0;
		mem_data    = '0;
		sweep_valid = 1'b0;
		sweep_x     = '0;
		sweep_exp   = '0;
		count_clear = 1'b0;
		count_check = 1'b0;
		count_exp   = 0;
		test_end    = 1'b0;
		run_done    = 1'b0;
		bp_on       = 1'b0;
		aborted     = 1'b0;
		for (i = 0; i < 65536; i++) begin
			mem[i] = 16'(i * 40503) ^ 16'h3c3c;
		end
		repeat (8) @(posedge CLK);
		RSTb <= 1'b1;

		fd = $fopen("tb/bg_tests.txt", "r");
		if (fd == 0) begin
			$display("Could not open tb/bg_tests.txt");
			aborted = 1'b1;
		end else begin
			while (!aborted && $fscanf(fd, "%s", cmd) == 1) begin
				if (cmd == "M") begin
					code = $fscanf(fd, "%h %h", a, b);
					if (code == 2) begin
						mem[a[15:0]] = b[15:0];
					end else begin
						report_bad_line(cmd);
					end
				end else if (cmd == "W") begin
					code = $fscanf(fd, "%h %h", a, b);
					if (code == 2) begin
						write_reg(a[3:0], b[15:0]);
					end else begin
						report_bad_line(cmd);
					end
				end else if (cmd == "L") begin
					code = $fscanf(fd, "%d", a);
					if (code == 1) begin
						render_line(a[9:0]);
					end else begin
						report_bad_line(cmd);
					end
				end else if (cmd == "S") begin
					swap_line();
				end else if (cmd == "B") begin
					code = $fscanf(fd, "%d", a);
					if (code == 1) begin
						bp_on <= a[0];
					end else begin
						report_bad_line(cmd);
					end
				end else if (cmd == "C") begin
					code = $fscanf(fd, "%d", a);
					if (code == 1) begin
						check_handshakes(a);
					end else begin
						report_bad_line(cmd);
					end
				end else if (cmd == "E") begin
					code = $fscanf(fd, "%d %h", a, b);
					if (code == 2) begin
						expect_pixel(a[9:0], b[7:0]);
					end else begin
						report_bad_line(cmd);
					end
				end else if (cmd == "T") begin
					close_test();
				end else if (cmd[0] == "#") begin
					code = $fgets(rest, fd);
				end else begin
					$display("Unknown command %s in the test file", cmd);
					aborted = 1'b1;
				end
			end
			$fclose(fd);
		end

		@(posedge CLK);
		run_done <= 1'b1;
		@(posedge CLK);
		run_done <= 1'b0;
		@(posedge CLK);
		if (aborted || error_count != 0) begin
			$display("Verification failed");
		end else begin
			$display("Verification passed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tb/bg_tests.txt
# Commands: M addr data, W reg value, L y, S, B backpressure, C handshakes, E x color, T
# Hex for addr, data, value and color; decimal for y, backpressure, handshakes and x
M 1000 2112
M 1001 00ff
M 1040 3400
M 1041 0005
M 2000 0000
M 2001 0001
M 4408 4321
M 4409 8765
M 440a cba9
M 440b 0fed
M 4804 00a5
M 4dd0 dcba
M 4dd3 6000
M 41d4 0090
M 6000 9876
M 6003 e000
M 6004 00c2
# Nothing enabled
L 0
C 0
S
E 0 00
E 400 00
T
# Layer 0 alone, byte parity, tile nibbles, transparent tile
W 0 0031
W 3 1000
W 4 4000
L 0
S
E 32 31
E 35 34
E 46 3f
E 47 00
E 48 35
E 49 3a
E 64 00
E 79 00
T
# Two layers under back-pressure
B 1
W 8 2000
W 9 6000
W 5 0071
L 0
S
E 32 31
E 47 7e
E 50 78
E 64 72
E 65 7c
E 66 70
T
# Fine scroll and row select under back-pressure
W 5 0000
W 1 0013
W 2 0005
L 18
S
E 29 3a
E 32 3d
E 44 36
E 45 00
E 46 39
T
